// File: source/softermax_params.svh
// ================================================
// Vector shape and fixed-point widths of the
// global normalization stage. Only the defaults
// below are supported by the datapath.
// ================================================
`ifndef SOFTERMAX_PARAMS_SVH
`define SOFTERMAX_PARAMS_SVH

// Vector shape
`define SM_TOTAL_DIM    16
`define SM_PARALLELISM  4
`define SM_DEPTH        (`SM_TOTAL_DIM / `SM_PARALLELISM)

// Unsigned power-of-two values and signed maxima
`define SM_VALUE_WIDTH  8
`define SM_VALUE_FRAC   4
`define SM_MAX_WIDTH    8
`define SM_MAX_FRAC     4

// Denominator and reciprocal, recip = 2^SHIFT / sum
`define SM_SUM_WIDTH    (`SM_VALUE_WIDTH + $clog2(`SM_TOTAL_DIM))
`define SM_RECIP_SHIFT  16
`define SM_RECIP_WIDTH  (`SM_RECIP_SHIFT + 1)
`define SM_OUT_WIDTH    8
`define SM_OUT_FRAC     7

`endif

// File: source/softermax_data_pkg.sv
// ================================================
// Datapath types of the normalization stage.
// Widths follow softermax_params.svh.
// ================================================
`default_nettype none

`include "softermax_params.svh"

package softermax_data_pkg;

    // Exponent value, input or after the shift
    typedef logic [`SM_VALUE_WIDTH-1:0] value_t;
    // Local or global maximum, two's complement
    typedef logic signed [`SM_MAX_WIDTH-1:0] max_t;
    // Right shift of 0 up to the full value width
    typedef logic [$clog2(`SM_VALUE_WIDTH):0] shift_t;
    typedef logic [`SM_SUM_WIDTH-1:0] sum_t;
    typedef logic [`SM_RECIP_WIDTH-1:0] recip_t;
    typedef logic [`SM_OUT_WIDTH-1:0] out_t;

endpackage

`default_nettype wire

// File: source/softermax_ctrl_pkg.sv
// ================================================
// Control types: phase encoding and beat index.
// ================================================
`default_nettype none

`include "softermax_params.svh"

package softermax_ctrl_pkg;

    typedef enum logic [1:0] {LOAD, RENORM, DIVIDE, EMIT} phase_t;

    // Index of a beat within one vector
    typedef logic [$clog2(`SM_DEPTH)-1:0] beat_idx_t;

endpackage

`default_nettype wire

// File: source/beat_if.sv
// ================================================
// One stored beat with its maxima, read by the
// renormalizer; adjusted values come back on the
// same link. Read side is combinational.
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "softermax_params.svh"

interface beat_if;
    import softermax_data_pkg::*;

    value_t [`SM_PARALLELISM-1:0] rd_values;
    max_t                         local_max;
    max_t                         global_max;
    value_t [`SM_PARALLELISM-1:0] wb_values;
    logic                         wb_en;

    modport store (
        output rd_values, local_max, global_max,
        input  wb_values, wb_en
    );

    modport renorm (
        input  rd_values, local_max, global_max,
        output wb_values, wb_en
    );
endinterface

`default_nettype wire

// File: source/norm_control.sv
// ================================================
// Phase FSM: LOAD, RENORM, DIVIDE, EMIT in turn.
// A new vector is accepted only after the last
// output beat of the previous one has left.
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "softermax_params.svh"

module norm_control (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           in_valid,
    output logic                          in_ready,
    input  wire                           out_ready,
    input  wire                           out_valid_q,
    output logic                          load_we,
    output softermax_ctrl_pkg::beat_idx_t load_idx,
    output logic                          clear,
    output logic                          renorm_en,
    output softermax_ctrl_pkg::beat_idx_t renorm_idx,
    output logic                          div_start,
    input  wire                           div_done,
    output logic                          emit_load,
    output softermax_ctrl_pkg::beat_idx_t emit_idx
);
    import softermax_ctrl_pkg::*;

    phase_t    phase;
    beat_idx_t cnt;
    logic      last_beat;
    logic      in_xfer;
    logic      out_xfer;

    assign last_beat = (cnt == beat_idx_t'(`SM_DEPTH - 1));
    assign in_xfer   = in_valid && in_ready;
    assign out_xfer  = out_valid_q && out_ready;

    assign in_ready   = (phase == LOAD);
    assign load_we    = in_xfer;
    assign load_idx   = cnt;
    // First beat restarts the global max and the denominator
    assign clear      = in_xfer && (cnt == '0);
    assign renorm_en  = (phase == RENORM);
    assign renorm_idx = cnt;
    // Next beat goes out once the scaler register is empty
    assign emit_load  = (phase == EMIT) && !out_valid_q;
    assign emit_idx   = cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= LOAD;
            cnt       <= '0;
            div_start <= 1'b0;
        end else begin
            // Divider starts once the last accumulation has landed
            div_start <= (phase == RENORM) && last_beat;
            case (phase)
                LOAD: begin
                    if (in_xfer) begin
                        cnt <= last_beat ? '0 : cnt + 1'b1;
                        if (last_beat)
                            phase <= RENORM;
                    end
                end
                RENORM: begin
                    cnt <= last_beat ? '0 : cnt + 1'b1;
                    if (last_beat)
                        phase <= DIVIDE;
                end
                DIVIDE: begin
                    if (div_done)
                        phase <= EMIT;
                end
                EMIT: begin
                    if (out_xfer) begin
                        cnt <= last_beat ? '0 : cnt + 1'b1;
                        if (last_beat)
                            phase <= LOAD;
                    end
                end
                default: phase <= LOAD;
            endcase
        end
    end
endmodule

`default_nettype wire

// File: source/beat_store.sv
// ================================================
// DEPTH-entry beat memory with a local max column.
// Load and write-back never happen in one cycle.
// Global max is valid after the last load beat.
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "softermax_params.svh"

module beat_store (
    input  wire                                                clk,
    input  wire                                                rst_n,
    input  wire softermax_data_pkg::value_t [`SM_PARALLELISM-1:0] in_values,
    input  wire softermax_data_pkg::max_t                      in_max,
    input  wire                                                load_we,
    input  wire softermax_ctrl_pkg::beat_idx_t                 load_idx,
    input  wire                                                clear,
    input  wire                                                renorm_en,
    input  wire softermax_ctrl_pkg::beat_idx_t                 renorm_idx,
    input  wire softermax_ctrl_pkg::beat_idx_t                 emit_idx,
    output softermax_data_pkg::value_t [`SM_PARALLELISM-1:0]   emit_values,
    beat_if.store                                              bif
);
    import softermax_data_pkg::*;

    value_t [`SM_PARALLELISM-1:0] val_mem [`SM_DEPTH];
    max_t                         max_mem [`SM_DEPTH];
    max_t                         global_max;

    // Beats are written on load and overwritten in place after the shift
    always_ff @(posedge clk) begin
        if (load_we) begin
            val_mem[load_idx] <= in_values;
            max_mem[load_idx] <= in_max;
        end else if (renorm_en && bif.wb_en) begin
            val_mem[renorm_idx] <= bif.wb_values;
        end
    end

    // Signed running maximum over the incoming local maxima
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            global_max <= '0;
        end else if (clear) begin
            global_max <= in_max;
        end else if (load_we && (in_max > global_max)) begin
            global_max <= in_max;
        end
    end

    assign bif.rd_values  = val_mem[renorm_idx];
    assign bif.local_max  = max_mem[renorm_idx];
    assign bif.global_max = global_max;

    assign emit_values = val_mem[emit_idx];
endmodule

`default_nettype wire

// File: source/renorm_sum.sv
// ================================================
// Integer part of (global - local) max sets the
// right shift, clamped to the value width. Only
// PARALLELISM = 4 fits the two-level adder tree.
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "softermax_params.svh"

module renorm_sum (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      clear,
    input  wire                      renorm_en,
    beat_if.renorm                   bif,
    output softermax_data_pkg::sum_t sum
);
    import softermax_data_pkg::*;

    logic signed [`SM_MAX_WIDTH:0] max_diff;
    logic signed [`SM_MAX_WIDTH:0] int_diff;
    shift_t                        shamt;
    value_t [`SM_PARALLELISM-1:0]  adjusted;
    logic [`SM_VALUE_WIDTH:0]      pair_sum [`SM_PARALLELISM/2];
    logic [`SM_VALUE_WIDTH+1:0]    beat_sum;

    assign max_diff = bif.global_max - bif.local_max;
    // Fraction bits dropped, only whole shifts are applied
    assign int_diff = max_diff >>> `SM_MAX_FRAC;

    always_comb begin
        if (int_diff < 0)
            shamt = '0;
        else if (int_diff > `SM_VALUE_WIDTH)
            shamt = shift_t'(`SM_VALUE_WIDTH);
        else
            shamt = shift_t'(int_diff);
    end

    for (genvar i = 0; i < `SM_PARALLELISM; i++) begin : g_shift
        assign adjusted[i] = bif.rd_values[i] >> shamt;
    end

    for (genvar p = 0; p < `SM_PARALLELISM/2; p++) begin : g_pair
        assign pair_sum[p] = {1'b0, adjusted[2*p]} + {1'b0, adjusted[2*p+1]};
    end
    assign beat_sum = {1'b0, pair_sum[0]} + {1'b0, pair_sum[1]};

    // Write-back happens on the same edge as the accumulation
    assign bif.wb_values = adjusted;
    assign bif.wb_en     = renorm_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sum <= '0;
        else if (clear)
            sum <= '0;
        else if (renorm_en)
            sum <= sum + sum_t'(beat_sum);
    end
endmodule

`default_nettype wire

// File: source/recip_divider.sv
// ================================================
// Restoring divider, 2^RECIP_SHIFT / sum, one
// quotient bit per cycle. div_done follows
// div_start by RECIP_WIDTH + 1 cycles.
// A zero sum yields an all-ones quotient.
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "softermax_params.svh"

module recip_divider (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        div_start,
    input  wire softermax_data_pkg::sum_t sum,
    output softermax_data_pkg::recip_t recip,
    output logic                       div_done
);
    import softermax_data_pkg::*;

    localparam int STEP_W = $clog2(`SM_RECIP_WIDTH);

    logic                   busy;
    logic [STEP_W-1:0]      step;
    sum_t                   rem;
    logic [`SM_SUM_WIDTH:0] trial;

    // Dividend bits shift out of the top of recip as quotient bits enter
    assign trial = {rem, recip[`SM_RECIP_WIDTH-1]};

    always_ff @(posedge clk) begin
        if (div_start) begin
            rem   <= '0;
            recip <= recip_t'(1 << `SM_RECIP_SHIFT);
        end else if (busy) begin
            if (trial >= {1'b0, sum}) begin
                rem   <= sum_t'(trial - {1'b0, sum});
                recip <= {recip[`SM_RECIP_WIDTH-2:0], 1'b1};
            end else begin
                rem   <= sum_t'(trial);
                recip <= {recip[`SM_RECIP_WIDTH-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step     <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == STEP_W'(`SM_RECIP_WIDTH - 1)) begin
                    busy     <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end
endmodule

`default_nettype wire

// File: source/norm_scaler.sv
// ================================================
// value * recip >> (RECIP_SHIFT - OUT_FRAC), with
// unsigned saturation. One beat in flight; data
// holds until the beat is taken.
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "softermax_params.svh"

module norm_scaler (
    input  wire                                                clk,
    input  wire                                                rst_n,
    input  wire                                                emit_load,
    input  wire softermax_data_pkg::value_t [`SM_PARALLELISM-1:0] emit_values,
    input  wire softermax_data_pkg::recip_t                    recip,
    input  wire                                                out_ready,
    output softermax_data_pkg::out_t [`SM_PARALLELISM-1:0]     out_data,
    output logic                                               out_valid
);
    import softermax_data_pkg::*;

    localparam int PROD_W = `SM_VALUE_WIDTH + `SM_RECIP_WIDTH;
    localparam int DROP   = `SM_RECIP_SHIFT - `SM_OUT_FRAC;

    logic [PROD_W-1:0]          scaled [`SM_PARALLELISM];
    out_t [`SM_PARALLELISM-1:0] sat;

    for (genvar i = 0; i < `SM_PARALLELISM; i++) begin : g_lane
        assign scaled[i] = (PROD_W'(emit_values[i]) * PROD_W'(recip)) >> DROP;
        // Clip anything above the output range
        assign sat[i] = (|scaled[i][PROD_W-1:`SM_OUT_WIDTH]) ? '1 : out_t'(scaled[i]);
    end

    always_ff @(posedge clk) begin
        if (emit_load)
            out_data <= sat;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (emit_load)
            out_valid <= 1'b1;
        else if (out_valid && out_ready)
            out_valid <= 1'b0;
    end
endmodule

`default_nettype wire

// File: source/softermax_global_norm.sv
// ================================================
// Softermax global renormalization, one vector at
// a time. Inputs stall from end of load until the
// last output beat is accepted.
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "softermax_params.svh"

module softermax_global_norm (
    input  wire                                                clk,
    input  wire                                                rst_n,
    input  wire softermax_data_pkg::value_t [`SM_PARALLELISM-1:0] in_values,
    input  wire softermax_data_pkg::max_t                      in_max,
    input  wire                                                in_valid,
    output logic                                               in_ready,
    output softermax_data_pkg::out_t [`SM_PARALLELISM-1:0]     out_data,
    output logic                                               out_valid,
    input  wire                                                out_ready
);
    import softermax_data_pkg::*;
    import softermax_ctrl_pkg::*;

    logic                         load_we;
    logic                         clear;
    logic                         renorm_en;
    logic                         div_start;
    logic                         div_done;
    logic                         emit_load;
    beat_idx_t                    load_idx;
    beat_idx_t                    renorm_idx;
    beat_idx_t                    emit_idx;
    value_t [`SM_PARALLELISM-1:0] emit_values;
    sum_t                         sum;
    recip_t                       recip;

    beat_if bif ();

    norm_control u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready),
        .out_ready(out_ready), .out_valid_q(out_valid),
        .load_we(load_we), .load_idx(load_idx), .clear(clear),
        .renorm_en(renorm_en), .renorm_idx(renorm_idx),
        .div_start(div_start), .div_done(div_done),
        .emit_load(emit_load), .emit_idx(emit_idx)
    );

    beat_store u_store (
        .clk(clk), .rst_n(rst_n),
        .in_values(in_values), .in_max(in_max),
        .load_we(load_we), .load_idx(load_idx), .clear(clear),
        .renorm_en(renorm_en), .renorm_idx(renorm_idx),
        .emit_idx(emit_idx), .emit_values(emit_values),
        .bif(bif.store)
    );

    renorm_sum u_renorm (
        .clk(clk), .rst_n(rst_n), .clear(clear), .renorm_en(renorm_en),
        .bif(bif.renorm), .sum(sum)
    );

    recip_divider u_div (
        .clk(clk), .rst_n(rst_n), .div_start(div_start),
        .sum(sum), .recip(recip), .div_done(div_done)
    );

    norm_scaler u_scale (
        .clk(clk), .rst_n(rst_n), .emit_load(emit_load),
        .emit_values(emit_values), .recip(recip), .out_ready(out_ready),
        .out_data(out_data), .out_valid(out_valid)
    );
endmodule

`default_nettype wire

// File: tests/softermax_global_norm_chk.sv
// ================================================
// Handshake assertions on the top level, bound
// into every softermax_global_norm instance.
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "softermax_params.svh"

module softermax_global_norm_chk (
    input wire                                                clk,
    input wire                                                rst_n,
    input wire                                                in_ready,
    input wire                                                out_valid,
    input wire                                                out_ready,
    input wire softermax_data_pkg::out_t [`SM_PARALLELISM-1:0] out_data
);
    // First clock after reset release
    a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else $error("out_valid high in the first cycle after reset");

    a_one_direction: assert property (@(posedge clk) disable iff (!rst_n)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid high together");

    a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> $stable(out_data))
        else $error("out_data changed while stalled");
endmodule

bind softermax_global_norm softermax_global_norm_chk chk (
    .clk(clk), .rst_n(rst_n), .in_ready(in_ready),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
);

`default_nettype wire

// File: tests/softermax_global_norm_tb.sv
// ================================================
// Random and directed vectors through the global
// normalization stage. Outputs are checked beat by
// beat against a model of the fixed-point rules.
// ================================================
`timescale 1ns/1ps
`default_nettype none

`include "softermax_params.svh"

module softermax_global_norm_tb;
    import softermax_data_pkg::*;

    localparam int NUM_VEC     = 40;
    localparam int CYCLE_LIMIT = NUM_VEC * 80;
    localparam int P           = `SM_PARALLELISM;

    typedef value_t [`SM_TOTAL_DIM-1:0] vec_t;
    typedef out_t [`SM_TOTAL_DIM-1:0]   outv_t;
    typedef max_t [`SM_DEPTH-1:0]       maxv_t;
    typedef out_t [P-1:0]               beat_t;

    logic               clk;
    logic               rst_n;
    value_t [P-1:0]     in_values;
    max_t               in_max;
    logic               in_valid;
    wire                in_ready;
    wire beat_t         out_data;
    wire                out_valid;
    logic               out_ready;
    logic               bp_en;
    logic               gap_en;
    int                 got_beats;
    int                 cycles;
    beat_t              exp_q [$];

    softermax_global_norm uut (
        .clk(clk), .rst_n(rst_n),
        .in_values(in_values), .in_max(in_max),
        .in_valid(in_valid), .in_ready(in_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Integer shift per beat, sum, floor reciprocal, scale and clip
    function automatic outv_t expected_vector(input vec_t vals, input maxv_t maxes);
        int     gmax;
        int     shamt;
        int     total;
        int     adj [`SM_TOTAL_DIM];
        longint recip;
        longint scaled;
        outv_t  res;
        gmax = $signed(maxes[0]);
        for (int b = 1; b < `SM_DEPTH; b++)
            if ($signed(maxes[b]) > gmax)
                gmax = $signed(maxes[b]);
        total = 0;
        for (int b = 0; b < `SM_DEPTH; b++) begin
            shamt = (gmax - $signed(maxes[b])) / (1 << `SM_MAX_FRAC);
            if (shamt > `SM_VALUE_WIDTH)
                shamt = `SM_VALUE_WIDTH;
            for (int i = 0; i < P; i++) begin
                adj[b*P+i] = int'(vals[b*P+i]) >> shamt;
                total += adj[b*P+i];
            end
        end
        if (total == 0)
            recip = (longint'(1) << `SM_RECIP_WIDTH) - 1;
        else
            recip = (longint'(1) << `SM_RECIP_SHIFT) / total;
        for (int k = 0; k < `SM_TOTAL_DIM; k++) begin
            scaled = (adj[k] * recip) >> (`SM_RECIP_SHIFT - `SM_OUT_FRAC);
            res[k] = (scaled > (1 << `SM_OUT_WIDTH) - 1) ? '1 : out_t'(scaled);
        end
        return res;
    endfunction

    task automatic check_value(input int got, input int exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "output value check failed");
        end
    endtask

    task automatic build_vector(input int n, output vec_t vals, output maxv_t maxes);
        int m;
        m = int'($urandom_range(0, 95)) - 48;
        for (int b = 0; b < `SM_DEPTH; b++) begin
            maxes[b] = max_t'(int'($urandom_range(0, 95)) - 48);
            for (int i = 0; i < P; i++)
                vals[b*P+i] = value_t'($urandom);
        end
        if (n >= 30 && n < 36) begin
            // Equal maxima, nothing shifted
            for (int b = 0; b < `SM_DEPTH; b++)
                maxes[b] = max_t'(m);
        end else if (n == 36) begin
            // Spread of more than 8 integer steps
            maxes[0] = max_t'(100);
            maxes[1] = max_t'(-60);
            maxes[2] = max_t'(40);
            maxes[3] = max_t'(-100);
        end else if (n == 37) begin
            vals = '0;
        end else if (n == 38) begin
            vals = '0;
            vals[9] = value_t'($urandom_range(1, 255));
            for (int b = 0; b < `SM_DEPTH; b++)
                maxes[b] = max_t'(m);
        end
    endtask

    // Called on a falling edge; returns on the falling edge after the transfer
    task automatic send_beat(input vec_t vals, input maxv_t maxes, input int b);
        logic taken;
        for (int i = 0; i < P; i++)
            in_values[i] = vals[b*P+i];
        in_max   = maxes[b];
        in_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            // in_ready only moves on a rising edge
            taken = in_ready;
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    initial begin : drive_inputs
        vec_t  vals;
        maxv_t maxes;
        outv_t exp_vec;
        beat_t beat;
        in_values = '0;
        in_max    = '0;
        in_valid  = 1'b0;
        rst_n     = 1'b0;
        bp_en     = 1'b0;
        gap_en    = 1'b0;
        void'($urandom(32'hf4bc));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < NUM_VEC; n++) begin
            bp_en  = (n >= 10);
            gap_en = (n >= 20 && n < 30);
            build_vector(n, vals, maxes);
            exp_vec = expected_vector(vals, maxes);
            for (int b = 0; b < `SM_DEPTH; b++) begin
                for (int i = 0; i < P; i++)
                    beat[i] = exp_vec[b*P+i];
                exp_q.push_back(beat);
            end
            for (int b = 0; b < `SM_DEPTH; b++) begin
                if (gap_en)
                    repeat ($urandom_range(0, 3)) @(negedge clk);
                send_beat(vals, maxes, b);
            end
        end
        // Last output beat leaves on the rising edge after the final count
        while (got_beats < NUM_VEC * `SM_DEPTH)
            @(posedge clk);
        @(negedge clk);
        if (in_ready && !out_valid) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("DUT did not return to loading after the last output beat");
            $display("*** TEST FAILED ***");
            $fatal(1, "no return to load phase");
        end
    end

    // Drives out_ready and checks the beat that leaves on the next rising edge
    initial begin : compare_outputs
        beat_t exp_beat;
        out_ready = 1'b0;
        got_beats = 0;
        wait (rst_n);
        forever begin
            @(negedge clk);
            out_ready = bp_en ? ($urandom_range(0, 2) != 0) : 1'b1;
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output beat appeared with no vector pending");
                    $display("*** TEST FAILED ***");
                    $fatal(1, "unexpected output");
                end
                exp_beat = exp_q.pop_front();
                for (int i = 0; i < P; i++)
                    check_value(out_data[i], exp_beat[i],
                        $sformatf("vector %0d beat %0d lane %0d",
                            got_beats / `SM_DEPTH, got_beats % `SM_DEPTH, i));
                got_beats++;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                $display("timeout: no result after %0d cycles", CYCLE_LIMIT);
                $display("*** TEST FAILED ***");
                $fatal(1, "timeout");
            end
        end
    end
endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/softermax_data_pkg.sv
source/softermax_ctrl_pkg.sv
source/beat_if.sv
source/norm_control.sv
source/beat_store.sv
source/renorm_sum.sv
source/recip_divider.sv
source/norm_scaler.sv
source/softermax_global_norm.sv
tests/softermax_global_norm_chk.sv
tests/softermax_global_norm_tb.sv

// File: Makefile
# Verilator build and run of the Softermax global normalization testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= softermax_global_norm_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The simulator exit status is the test result
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
